//--- common/rv_pkg.sv
/*
 * Shared definitions for the five-stage RV32I subset pipeline.
 * Holds the widths, the opcode map, the ALU operation type, the
 * instruction word with its format views, and the control bundle
 * that travels from decode down to writeback.
 */
package rv_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  // opcode map in inst[6:0]
  localparam logic [6:0] op_r       = 7'b0110011;
  localparam logic [6:0] op_i_arith = 7'b0010011;
  localparam logic [6:0] op_load    = 7'b0000011;
  localparam logic [6:0] op_store   = 7'b0100011;
  localparam logic [6:0] op_branch  = 7'b1100011;
  localparam logic [6:0] op_lui     = 7'b0110111;
  localparam logic [6:0] op_jal     = 7'b1101111;

  localparam logic [2:0] f3_beq = 3'b000;
  localparam logic [2:0] f3_bne = 3'b001;

  typedef enum logic [1:0] {
    alu_add = 2'b00,
    alu_sub = 2'b01,
    alu_and = 2'b10,
    alu_or  = 2'b11
  } alu_op_t;

  // ************************************************************
  // instruction word, one view per encoding format
  // ************************************************************
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r_fmt;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_fmt;
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } s_fmt;
    struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
    } b_fmt;
    struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j_fmt;
    struct packed {
      logic [19:0] imm;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u_fmt;
  } inst_t;

  typedef struct packed {
    logic    reg_write;
    logic    alu_src;    // second operand is the immediate
    logic    mem_to_reg;
    logic    mem_write;
    logic    branch;
    logic    jal;
    logic    lui;
    alu_op_t alu_op;
  } ctrl_t;

  localparam inst_t nop_inst = 32'h0000_0013; // addi x0, x0, 0

endpackage

//--- common/ex_bundle_if.sv
/*
 * One decoded instruction on its way from decode into execute.
 * Every signal is registered in decode and moves on each clock;
 * a bubble has valid low and all ctrl bits clear.
 */
`timescale 1ns/100ps

interface ex_bundle_if
  import rv_pkg::*;
();
  logic                  valid;
  ctrl_t                 ctrl;
  logic [xlen-1:0]       pc;
  inst_t                 inst;
  logic [xlen-1:0]       rs1_data;
  logic [xlen-1:0]       rs2_data;
  logic [xlen-1:0]       imm;      // I, S or U immediate already chosen
  logic [reg_addr_w-1:0] rs1;
  logic [reg_addr_w-1:0] rs2;
  logic [reg_addr_w-1:0] rd;

  modport decode  (output valid, ctrl, pc, inst, rs1_data, rs2_data, imm, rs1, rs2, rd);
  modport execute (input  valid, ctrl, pc, inst, rs1_data, rs2_data, imm, rs1, rs2, rd);

endinterface

//--- decode/inst_decoder.sv
/*
 * Main and ALU decoder. Turns the opcode, and for R-type the funct
 * fields, into the control bundle. Unknown opcodes give no controls.
 */
`timescale 1ns/100ps

module inst_decoder
  import rv_pkg::*;
(
  input  inst_t inst,
  output ctrl_t ctrl
);

  always_comb
  begin
    ctrl        = '0;
    ctrl.alu_op = alu_add;   // loads, stores, lui and jal all add
    case (inst.r_fmt.opcode)
      op_r:
      begin
        ctrl.reg_write = 1'b1;
        case ({inst.r_fmt.funct7, inst.r_fmt.funct3})
          10'b0100000_000: ctrl.alu_op = alu_sub;
          10'b0000000_111: ctrl.alu_op = alu_and;
          10'b0000000_110: ctrl.alu_op = alu_or;
          default:         ctrl.alu_op = alu_add;
        endcase
      end
      op_i_arith:
      begin
        ctrl.reg_write = 1'b1;  // addi only
        ctrl.alu_src   = 1'b1;
      end
      op_load:
      begin
        ctrl.reg_write  = 1'b1;
        ctrl.alu_src    = 1'b1;
        ctrl.mem_to_reg = 1'b1;
      end
      op_store:
      begin
        ctrl.alu_src   = 1'b1;
        ctrl.mem_write = 1'b1;
      end
      op_branch:
      begin
        ctrl.branch = 1'b1;
        ctrl.alu_op = alu_sub;  // compare through the zero flag
      end
      op_lui:
      begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.lui       = 1'b1;
      end
      op_jal:
      begin
        ctrl.reg_write = 1'b1;
        ctrl.jal       = 1'b1;
      end
      default:
        ctrl = '0;
    endcase
  end

endmodule

//--- decode/reg_file.sv
/*
 * 32 x 32 register file, two read ports and one write port.
 * x0 reads as zero; a read of the register being written in the
 * same cycle returns the new value.
 */
`timescale 1ns/100ps

module reg_file
  import rv_pkg::*;
(
  input  logic                  clk,
  input  logic                  we,
  input  logic [reg_addr_w-1:0] rs1,
  input  logic [reg_addr_w-1:0] rs2,
  input  logic [reg_addr_w-1:0] rd,
  input  logic [xlen-1:0]       rd_data,
  output logic [xlen-1:0]       rs1_data,
  output logic [xlen-1:0]       rs2_data
);
  logic [xlen-1:0] regs [2**reg_addr_w];

  always_ff @(posedge clk)
  begin
    if (we && rd != '0)
      regs[rd] <= rd_data;
  end

  // write-through read
  assign rs1_data = (rs1 == '0) ? '0 : (we && rd == rs1) ? rd_data : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : (we && rd == rs2) ? rd_data : regs[rs2];

endmodule

//--- decode/decode_stage.sv
/*
 * Decode stage. Holds the fetch/decode register, reads the register
 * file, builds the I/S/U immediate and fills the decode/execute
 * bundle. A load in execute feeding this instruction stalls one cycle.
 */
`timescale 1ns/100ps

module decode_stage
  import rv_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic [xlen-1:0]       pc,
  input  logic [xlen-1:0]       inst,
  input  logic                  redirect,
  input  logic                  wb_reg_write,
  input  logic [reg_addr_w-1:0] wb_rd,
  input  logic [xlen-1:0]       wb_data,
  output logic                  stall,
  ex_bundle_if.decode           ex
);
  inst_t           id_inst;
  logic [xlen-1:0] id_pc;
  logic            id_valid;
  ctrl_t           id_ctrl;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  logic [xlen-1:0] imm;
  logic            load_in_ex;

  // ************************************************************
  // fetch/decode register
  // ************************************************************
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      id_inst  <= nop_inst;
      id_valid <= 1'b0;
    end
    else if (redirect)
    begin
      id_inst  <= nop_inst;
      id_valid <= 1'b0;
    end
    else if (!stall)
    begin
      id_inst  <= inst;
      id_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!stall)
      id_pc <= pc;
  end

  inst_decoder inst_decoder_i (
    .inst (id_inst),
    .ctrl (id_ctrl)
  );

  reg_file reg_file_i (
    .clk      (clk),
    .we       (wb_reg_write),
    .rs1      (id_inst.r_fmt.rs1),
    .rs2      (id_inst.r_fmt.rs2),
    .rd       (wb_rd),
    .rd_data  (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  always_comb
  begin
    if (id_ctrl.lui)
      imm = {id_inst.u_fmt.imm, 12'b0};
    else if (id_ctrl.mem_write)  // S format
      imm = {{20{id_inst.s_fmt.imm_hi[6]}}, id_inst.s_fmt.imm_hi, id_inst.s_fmt.imm_lo};
    else
      imm = {{20{id_inst.i_fmt.imm[11]}}, id_inst.i_fmt.imm};
  end

  // load-use hazard where the loaded value is not ready for forwarding yet
  assign load_in_ex = ex.valid & ex.ctrl.mem_to_reg & (ex.rd != '0);
  assign stall      = load_in_ex & id_valid &
                      ((ex.rd == id_inst.r_fmt.rs1) | (ex.rd == id_inst.r_fmt.rs2));

  // ************************************************************
  // decode/execute register
  // ************************************************************
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      ex.valid <= 1'b0;
      ex.ctrl  <= '0;
    end
    else if (redirect || stall || !id_valid)
    begin
      ex.valid <= 1'b0;  // bubble
      ex.ctrl  <= '0;
    end
    else
    begin
      ex.valid <= 1'b1;
      ex.ctrl  <= id_ctrl;
    end
  end

  always_ff @(posedge clk)
  begin
    ex.pc       <= id_pc;
    ex.inst     <= id_inst;
    ex.rs1_data <= rs1_data;
    ex.rs2_data <= rs2_data;
    ex.imm      <= imm;
    ex.rs1      <= id_inst.r_fmt.rs1;
    ex.rs2      <= id_inst.r_fmt.rs2;
    ex.rd       <= id_inst.r_fmt.rd;
  end

endmodule

//--- execute/execute_stage.sv
/*
 * Execute stage. Forwards operands from the memory and writeback
 * stages, runs the ALU, resolves beq/bne/jal and drives the
 * execute/memory register, whose ALU result is the data address.
 */
`timescale 1ns/100ps

module execute_stage
  import rv_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  ex_bundle_if.execute          ex,
  input  logic                  wb_reg_write,
  input  logic [reg_addr_w-1:0] wb_rd,
  input  logic [xlen-1:0]       wb_data,
  output logic                  redirect,
  output logic [xlen-1:0]       target,
  output logic                  mem_write,
  output logic [xlen-1:0]       mem_addr,
  output logic [xlen-1:0]       mem_wdata,
  output ctrl_t                 mem_ctrl,
  output logic [reg_addr_w-1:0] mem_rd,
  output logic [xlen-1:0]       mem_alu_out,
  output logic [xlen-1:0]       mem_pc
);
  logic [xlen-1:0] fwd_a;
  logic [xlen-1:0] fwd_b;
  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic [xlen-1:0] alu_out;
  logic [xlen-1:0] b_imm;
  logic [xlen-1:0] j_imm;
  logic            zero;
  logic            taken;

  // newest producer wins with memory stage before writeback
  function automatic logic [xlen-1:0] fwd_sel(
    input logic [reg_addr_w-1:0] rs,
    input logic [xlen-1:0]       rf_val
  );
    if (mem_ctrl.reg_write && mem_rd != '0 && mem_rd == rs)
      return mem_alu_out;
    else if (wb_reg_write && wb_rd != '0 && wb_rd == rs)
      return wb_data;
    else
      return rf_val;
  endfunction

  always_comb
  begin
    fwd_a = fwd_sel(ex.rs1, ex.rs1_data);
    fwd_b = fwd_sel(ex.rs2, ex.rs2_data);  // also the store data
  end

  assign op_a = ex.ctrl.lui ? '0 : fwd_a;
  assign op_b = ex.ctrl.alu_src ? ex.imm : fwd_b;

  always_comb
  begin
    case (ex.ctrl.alu_op)
      alu_sub: alu_out = op_a - op_b;
      alu_and: alu_out = op_a & op_b;
      alu_or:  alu_out = op_a | op_b;
      default: alu_out = op_a + op_b;
    endcase
  end

  assign zero = (alu_out == '0);

  // ************************************************************
  // branch and jump resolution
  // ************************************************************
  assign b_imm = {{19{ex.inst.b_fmt.imm_12}}, ex.inst.b_fmt.imm_12, ex.inst.b_fmt.imm_11,
                  ex.inst.b_fmt.imm_10_5, ex.inst.b_fmt.imm_4_1, 1'b0};
  assign j_imm = {{11{ex.inst.j_fmt.imm_20}}, ex.inst.j_fmt.imm_20, ex.inst.j_fmt.imm_19_12,
                  ex.inst.j_fmt.imm_11, ex.inst.j_fmt.imm_10_1, 1'b0};

  assign taken = ex.ctrl.branch &
                 (((ex.inst.b_fmt.funct3 == f3_beq) & zero) |
                  ((ex.inst.b_fmt.funct3 == f3_bne) & ~zero));

  assign redirect = ex.valid & (taken | ex.ctrl.jal);  // flushes the two younger slots
  assign target   = ex.pc + (ex.ctrl.jal ? j_imm : b_imm);

  // ************************************************************
  // execute/memory register
  // ************************************************************
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      mem_ctrl <= '0;
    else
      mem_ctrl <= ex.valid ? ex.ctrl : '0;
  end

  always_ff @(posedge clk)
  begin
    mem_rd      <= ex.rd;
    mem_alu_out <= alu_out;
    mem_wdata   <= fwd_b;
    mem_pc      <= ex.pc;
  end

  assign mem_write = mem_ctrl.mem_write;
  assign mem_addr  = mem_alu_out;

endmodule

//--- hdl/fetch_stage.sv
/*
 * Program counter. Steps by 4 each cycle, holds during a load-use
 * stall, and jumps to the execute-stage target on redirect.
 */
`timescale 1ns/100ps

module fetch_stage
  import rv_pkg::*;
(
  input  logic            clk,
  input  logic            reset,
  input  logic            stall,
  input  logic            redirect,
  input  logic [xlen-1:0] target,
  output logic [xlen-1:0] pc
);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      pc <= '0;
    else if (redirect)          // taken branch or jal beats a stall
      pc <= target;
    else if (!stall)
      pc <= pc + xlen'(4);
  end

endmodule

//--- hdl/writeback_stage.sv
/*
 * Memory/writeback register and the register write value.
 * Captures the load data at the end of the memory cycle; the wb
 * outputs feed the register file and both forwarding paths.
 */
`timescale 1ns/100ps

module writeback_stage
  import rv_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  ctrl_t                 mem_ctrl,
  input  logic [reg_addr_w-1:0] mem_rd,
  input  logic [xlen-1:0]       mem_alu_out,
  input  logic [xlen-1:0]       mem_pc,
  input  logic [xlen-1:0]       mem_rdata,
  output logic                  wb_reg_write,
  output logic [reg_addr_w-1:0] wb_rd,
  output logic [xlen-1:0]       wb_data
);
  logic            wb_mem_to_reg;
  logic            wb_jal;
  logic [xlen-1:0] wb_alu_out;
  logic [xlen-1:0] wb_pc;
  logic [xlen-1:0] wb_rdata;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      wb_reg_write  <= 1'b0;
      wb_mem_to_reg <= 1'b0;
      wb_jal        <= 1'b0;
    end
    else
    begin
      wb_reg_write  <= mem_ctrl.reg_write;
      wb_mem_to_reg <= mem_ctrl.mem_to_reg;
      wb_jal        <= mem_ctrl.jal;
    end
  end

  always_ff @(posedge clk)
  begin
    wb_rd      <= mem_rd;
    wb_alu_out <= mem_alu_out;
    wb_pc      <= mem_pc;
    wb_rdata   <= mem_rdata;  // load data
  end

  always_comb
  begin
    if (wb_jal)
      wb_data = wb_pc + xlen'(4);  // link address
    else if (wb_mem_to_reg)
      wb_data = wb_rdata;
    else
      wb_data = wb_alu_out;
  end

endmodule

//--- hdl/rv_pipe_cpu.sv
/*
 * Top of the five-stage pipelined RV32I subset core.
 * Instruction port is combinational on pc; data memory read data
 * must be valid in the same cycle as mem_addr.
 */
`timescale 1ns/100ps

module rv_pipe_cpu
  import rv_pkg::*;
(
  input  logic            clk,
  input  logic            reset,
  output logic [xlen-1:0] pc,
  input  logic [xlen-1:0] inst,
  output logic            mem_write,
  output logic [xlen-1:0] mem_addr,
  output logic [xlen-1:0] mem_wdata,
  input  logic [xlen-1:0] mem_rdata
);
  logic                  stall;
  logic                  redirect;
  logic [xlen-1:0]       target;
  ctrl_t                 mem_ctrl;
  logic [reg_addr_w-1:0] mem_rd;
  logic [xlen-1:0]       mem_alu_out;
  logic [xlen-1:0]       mem_pc;
  logic                  wb_reg_write;
  logic [reg_addr_w-1:0] wb_rd;
  logic [xlen-1:0]       wb_data;

  ex_bundle_if ex_bus ();

  fetch_stage fetch_stage_i (
    .clk      (clk),
    .reset    (reset),
    .stall    (stall),
    .redirect (redirect),
    .target   (target),
    .pc       (pc)
  );

  decode_stage decode_stage_i (
    .clk          (clk),
    .reset        (reset),
    .pc           (pc),
    .inst         (inst),
    .redirect     (redirect),
    .wb_reg_write (wb_reg_write),
    .wb_rd        (wb_rd),
    .wb_data      (wb_data),
    .stall        (stall),
    .ex           (ex_bus.decode)
  );

  execute_stage execute_stage_i (
    .clk          (clk),
    .reset        (reset),
    .ex           (ex_bus.execute),
    .wb_reg_write (wb_reg_write),
    .wb_rd        (wb_rd),
    .wb_data      (wb_data),
    .redirect     (redirect),
    .target       (target),
    .mem_write    (mem_write),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .mem_ctrl     (mem_ctrl),
    .mem_rd       (mem_rd),
    .mem_alu_out  (mem_alu_out),
    .mem_pc       (mem_pc)
  );

  writeback_stage writeback_stage_i (
    .clk          (clk),
    .reset        (reset),
    .mem_ctrl     (mem_ctrl),
    .mem_rd       (mem_rd),
    .mem_alu_out  (mem_alu_out),
    .mem_pc       (mem_pc),
    .mem_rdata    (mem_rdata),
    .wb_reg_write (wb_reg_write),
    .wb_rd        (wb_rd),
    .wb_data      (wb_data)
  );

endmodule

//--- dv/rv_pipe_cpu_tb.sv
/*
 * Testbench for the pipelined RV32I subset core.
 * Runs a table of short programs. Each row is loaded into the
 * instruction memory model, the core is reset, and a chosen store
 * is compared with the address, data and pc worked out from the ISA.
 */
`timescale 1ns/100ps

module rv_pipe_cpu_tb;

  localparam int          n_tests  = 7;
  localparam int          period   = 4;
  localparam logic [31:0] nop_word = 32'h0000_0013;  // addi x0, x0, 0

  logic        clk;
  logic        reset;
  logic [31:0] pc;
  logic [31:0] inst;
  logic        mem_write;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic [31:0] mem_rdata;

  logic [31:0] imem [32];
  logic [31:0] dmem [64];

  string       test_name [n_tests];
  logic [31:0] prog      [n_tests][8];
  logic [31:0] exp_addr  [n_tests];
  logic [31:0] exp_data  [n_tests];
  logic [31:0] exp_pc    [n_tests];
  int          store_no  [n_tests];  // which store of the run is checked
  int          n_pass;
  int          n_fail;

  rv_pipe_cpu rv_pipe_cpu_i (
    .clk       (clk),
    .reset     (reset),
    .pc        (pc),
    .inst      (inst),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata)
  );

  always #(period / 2) clk = ~clk;

  // memory models driven on the falling edge
  always @(negedge clk)
  begin
    if (mem_write)
      dmem[mem_addr[7:2]] = mem_wdata;
    inst      <= imem[pc[6:2]];
    mem_rdata <= dmem[mem_addr[7:2]];
  end

  // ************************************************************
  // instruction encoders, straight from the RV32I formats
  // ************************************************************
  function automatic logic [31:0] alu_rr(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] add_imm(input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [31:0] imm);
    return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] load_word(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [31:0] imm);
    return {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
  endfunction

  function automatic logic [31:0] store_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                             input logic [31:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] branch_op(input logic [2:0] f3, input logic [4:0] rs1,
                                            input logic [4:0] rs2, input logic [31:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jump_link(input logic [4:0] rd, input logic [31:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [31:0] load_upper(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  task automatic set_row(input int r, input string nm, input logic [31:0] addr,
                         input logic [31:0] data, input int nth,
                         input logic [31:0] spc);
    test_name[r] = nm;
    exp_addr[r]  = addr;
    exp_data[r]  = data;
    exp_pc[r]    = spc + 32'd12;  // three younger fetches behind the store
    store_no[r]  = nth;
    for (int k = 0; k < 8; k++)
      prog[r][k] = nop_word;
  endtask

  // ************************************************************
  // program table
  // ************************************************************
  task automatic build_table();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    logic [31:0] e;
    a = 32'h5a3;
    b = a + 32'h2c6;
    c = b + a;
    d = a - c;
    e = d & c;
    set_row(0, "arith_forwarding", 32'd16, e | b, 0, 32'd24);
    prog[0][0] = add_imm(1, 0, 32'h5a3);
    prog[0][1] = add_imm(2, 1, 32'h2c6);
    prog[0][2] = alu_rr(7'h00, 3'b000, 3, 2, 1);  // add
    prog[0][3] = alu_rr(7'h20, 3'b000, 4, 1, 3);  // sub
    prog[0][4] = alu_rr(7'h00, 3'b111, 5, 4, 3);  // and
    prog[0][5] = alu_rr(7'h00, 3'b110, 6, 5, 2);  // or
    prog[0][6] = store_word(6, 0, 32'd16);

    set_row(1, "lui_store_data", 32'd64 + 32'd8, 32'h1234_5000 + 32'h678, 0, 32'd12);
    prog[1][0] = add_imm(8, 0, 32'd64);
    prog[1][1] = load_upper(7, 20'h12345);
    prog[1][2] = add_imm(7, 7, 32'h678);
    prog[1][3] = store_word(7, 8, 32'd8);  // data straight from the memory stage

    set_row(2, "load_use_stall", 32'd32 + 32'd12, 32'h3c1 + 32'd77, 1, 32'd20);
    prog[2][0] = add_imm(9, 0, 32'h3c1);
    prog[2][1] = add_imm(10, 0, 32'd32);
    prog[2][2] = store_word(9, 10, 32'd4);
    prog[2][3] = load_word(11, 10, 32'd4);
    prog[2][4] = add_imm(12, 11, 32'd77);
    prog[2][5] = store_word(12, 10, 32'd12);

    // bne falls through and beq is taken over two poison slots
    set_row(3, "bne_not_beq_taken", 32'd80, 32'd5 + 32'd16, 0, 32'd28);
    prog[3][0] = add_imm(13, 0, 32'd5);
    prog[3][1] = add_imm(14, 0, 32'd5);
    prog[3][2] = branch_op(3'b001, 13, 14, 32'd8);
    prog[3][3] = add_imm(13, 13, 32'd16);
    prog[3][4] = branch_op(3'b000, 13, 13, 32'd12);
    prog[3][5] = add_imm(13, 13, 32'd1);
    prog[3][6] = add_imm(13, 13, 32'd2);
    prog[3][7] = store_word(13, 0, 32'd80);

    set_row(4, "beq_not_bne_taken", 32'd84, 32'd9 + 32'd100, 0, 32'd28);
    prog[4][0] = add_imm(15, 0, 32'd9);
    prog[4][1] = add_imm(16, 0, 32'd3);
    prog[4][2] = branch_op(3'b000, 15, 16, 32'd8);
    prog[4][3] = add_imm(15, 15, 32'd100);
    prog[4][4] = branch_op(3'b001, 15, 16, 32'd12);
    prog[4][5] = add_imm(15, 15, 32'd1);
    prog[4][6] = add_imm(15, 15, 32'd2);
    prog[4][7] = store_word(15, 0, 32'd84);

    set_row(5, "jal_link", 32'd88, 32'd4 + 32'd4, 0, 32'd16);  // jal sits at pc 4
    prog[5][0] = add_imm(18, 0, 32'd7);
    prog[5][1] = jump_link(18, 32'd12);
    prog[5][2] = add_imm(18, 18, 32'd1);
    prog[5][3] = add_imm(18, 18, 32'd2);
    prog[5][4] = store_word(18, 0, 32'd88);

    set_row(6, "x0_write_ignored", 32'd92, 32'd0, 0, 32'd4);
    prog[6][0] = add_imm(0, 0, 32'd123);
    prog[6][1] = store_word(0, 0, 32'd92);
  endtask

  // reset, load one row, wait for its store and compare
  task automatic run_row(input int r);
    int   seen;
    logic done;
    seen = 0;
    done = 1'b0;
    @(negedge clk);
    reset = 1'b1;
    for (int k = 0; k < 32; k++)
    begin
      if (k < 8)
        imem[k] = prog[r][k];
      else
        imem[k] = nop_word;
    end
    for (int k = 0; k < 64; k++)
      dmem[k] = $urandom;
    repeat (16) @(negedge clk);
    reset = 1'b0;
    while (!done)
    begin
      @(negedge clk);
      if (mem_write)
      begin
        if (seen == store_no[r])
          done = 1'b1;
        seen++;
      end
    end
    if (mem_addr !== exp_addr[r])
    begin
      $display("Error %s: store address expected %h, actual %h",
               test_name[r], exp_addr[r], mem_addr);
      n_fail++;
    end
    else if (mem_wdata !== exp_data[r])
    begin
      $display("Error %s: store data expected %h, actual %h",
               test_name[r], exp_data[r], mem_wdata);
      n_fail++;
    end
    else if (pc !== exp_pc[r])
    begin
      $display("Error %s: pc expected %h, actual %h",
               test_name[r], exp_pc[r], pc);
      n_fail++;
    end
    else
    begin
      $display("pass %s: wrote %h to %h", test_name[r], mem_wdata, mem_addr);
      n_pass++;
    end
  endtask

  initial
  begin
    clk       = 1'b0;
    reset     = 1'b1;
    inst      = nop_word;
    mem_rdata = '0;
    n_pass    = 0;
    n_fail    = 0;
    void'($urandom(61004));
    build_table();
    for (int r = 0; r < n_tests; r++)
      run_row(r);
    $display("%0d tests, %0d passed, %0d failed", n_tests, n_pass, n_fail);
    if (n_fail == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

  // watchdog allows 64 cycles per row
  initial
  begin
    repeat (n_tests * 64) @(posedge clk);
    $display("timeout: the expected store was never seen");
    $display("Checks failed");
    $finish;
  end

endmodule

//--- src.f
common/rv_pkg.sv
common/ex_bundle_if.sv
decode/inst_decoder.sv
decode/reg_file.sv
decode/decode_stage.sv
execute/execute_stage.sv
hdl/fetch_stage.sv
hdl/writeback_stage.sv
hdl/rv_pipe_cpu.sv
dv/rv_pipe_cpu_tb.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator, then check the log

rm -f sim.log &&
verilator --binary --timing -f src.f --top-module rv_pipe_cpu_tb -o rv_pipe_cpu_sim &&
./obj_dir/rv_pipe_cpu_sim | tee sim.log &&
! grep -q "Checks failed" sim.log &&
echo "simulation run passed" ||
{ echo "simulation run failed"; exit 1; }
